// File: sources.f
source/csr_arch_pkg.sv
source/csr_ctrl_pkg.sv
source/csr_decode.sv
source/csr_sequencer.sv
source/csr_bit_unit.sv
source/csr_shift_rf.sv
source/csr_result.sv
source/csr_top.sv
sim/tb_csr_top.sv

// File: Bender.yml
package:
  name: csr_serial_unit

sources:
  - source/csr_arch_pkg.sv
  - source/csr_ctrl_pkg.sv
  - source/csr_decode.sv
  - source/csr_sequencer.sv
  - source/csr_bit_unit.sv
  - source/csr_shift_rf.sv
  - source/csr_result.sv
  - source/csr_top.sv
  - target: test
    files:
      - sim/tb_csr_top.sv

// File: sim/tb_csr_top.sv
`timescale 1ns/1ns

module tb_csr_top;
   import csr_arch_pkg::*;
   import csr_ctrl_pkg::*;

   localparam int          NUM_RAND    = 300;
   localparam int          NUM_DIRECT  = 40;
   localparam int          CYCLE_LIMIT = (NUM_RAND + NUM_DIRECT) * 40 + 400;
   localparam logic [31:0] ALL         = 32'hFFFF_FFFF;

   logic        i_clk;
   logic        i_rst;
   logic        i_cmd_valid;
   cmd_op_e     i_cmd_op;
   logic [11:0] i_cmd_addr;
   logic [31:0] i_cmd_data;
   logic        o_cmd_ready;
   logic        o_rsp_valid;
   logic [31:0] o_rsp_data;
   logic        i_rsp_ready;
   logic        i_mtip;
   logic        o_new_irq;

   // Reference CSR state
   logic [31:0] ref_mstatus;
   logic [31:0] ref_mie;
   logic [31:0] ref_mcause;
   logic [31:0] ref_mscratch;
   logic [31:0] ref_mtvec;

   logic [31:0] rng;
   logic [31:0] exp_q[$];
   logic [31:0] care_q[$];
   int          mon_cyc;
   int          acc_cyc;
   int          timeout_cyc;
   logic        acc_trap;
   logic        irq_pred;
   logic        mtip_last;
   logic        valid_last;
   logic        stalled_last;
   logic [31:0] held_data;
   logic [31:0] exp_data;
   logic [31:0] care;

   csr_top uut (
      .i_clk(i_clk), .i_rst(i_rst), .i_cmd_valid(i_cmd_valid), .i_cmd_op(i_cmd_op),
      .i_cmd_addr(i_cmd_addr), .i_cmd_data(i_cmd_data), .o_cmd_ready(o_cmd_ready),
      .o_rsp_valid(o_rsp_valid), .o_rsp_data(o_rsp_data), .i_rsp_ready(i_rsp_ready),
      .i_mtip(i_mtip), .o_new_irq(o_new_irq)
   );

   initial begin
      i_clk = 1'b0;
      forever #2 i_clk = ~i_clk;
   end

   // **************************************************
   // Random numbers and reference model
   // **************************************************
   function automatic logic [31:0] lcg_next();
      rng = rng * 32'd1664525 + 32'd1013904223;
      return rng;
   endfunction

   function automatic int pick(input int n);
      logic [31:0] r;
      r = lcg_next();
      return int'((r >> 16) % n);
   endfunction

   // Returns the old CSR value and applies the command to the model
   function automatic logic [31:0] csr_ref(input cmd_op_e op, input logic [11:0] addr,
                                           input logic [31:0] data, input logic mtip);
      logic [31:0] old_v;
      logic [31:0] new_v;
      if (op != OP_RW && op != OP_RS && op != OP_RC) begin
         if (mtip && ref_mstatus[3] && ref_mie[7]) ref_mcause = 32'h8000_0007;
         else if (op == OP_ECALL) ref_mcause = 32'd11;
         else if (op == OP_EBREAK) ref_mcause = 32'd3;
         else if (op == OP_LD_MISALIGN) ref_mcause = 32'd4;
         else ref_mcause = 32'd6;
         return 32'h0;
      end
      case (addr)
         CSR_MSTATUS:  old_v = ref_mstatus;
         CSR_MIE:      old_v = ref_mie;
         CSR_MCAUSE:   old_v = ref_mcause;
         CSR_MSCRATCH: old_v = ref_mscratch;
         CSR_MTVEC:    old_v = ref_mtvec;
         default:      return 32'h0;
      endcase
      case (op)
         OP_RW:   new_v = data;
         OP_RS:   new_v = old_v | data;
         default: new_v = old_v & ~data;
      endcase
      case (addr)
         CSR_MSTATUS:  ref_mstatus = new_v & 32'h0000_0008;
         CSR_MIE:      ref_mie = new_v & 32'h0000_0080;
         CSR_MCAUSE:   ref_mcause = new_v & 32'h8000_000F;
         CSR_MSCRATCH: ref_mscratch = new_v;
         default:      ref_mtvec = new_v;
      endcase
      return old_v;
   endfunction

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("TEST FAIL");
      $fatal(1, "%s", why);
   endtask

   task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
         $display("TEST FAIL");
         $fatal(1, "%s mismatch", what);
      end
   endtask

   // **************************************************
   // Stimulus
   // **************************************************
   task automatic tick();
      @(posedge i_clk);
      #1;
   endtask

   // Two cycles let the interrupt edge settle before the next command
   task automatic set_mtip(input logic v);
      i_mtip = v;
      repeat (2) tick();
   endtask

   task automatic send_cmd(input cmd_op_e op, input logic [11:0] addr, input logic [31:0] data,
                           input logic [31:0] mask, input int stall);
      logic taken;
      int   hold;
      exp_q.push_back(csr_ref(op, addr, data, i_mtip));
      care_q.push_back(mask);
      hold        = stall;
      i_cmd_valid = 1'b1;
      i_cmd_op    = op;
      i_cmd_addr  = addr;
      i_cmd_data  = data;
      i_rsp_ready = (hold == 0);
      do begin
         @(posedge i_clk);
      end while (!o_cmd_ready);
      #1;
      i_cmd_valid = 1'b0;
      taken       = 1'b0;
      while (!taken) begin
         @(posedge i_clk);
         taken = o_rsp_valid & i_rsp_ready;
         if (o_rsp_valid && hold > 0) hold--;
         #1;
         i_rsp_ready = (hold == 0);
      end
   endtask

   initial begin
      logic [11:0] csr_tab[6];
      logic [11:0] addr;
      logic [31:0] hi;
      logic [31:0] lo;
      int          idx;
      int          stall;
      csr_tab = '{CSR_MSTATUS, CSR_MIE, CSR_MCAUSE, CSR_MSCRATCH, CSR_MTVEC, 12'h301};
      rng          = 32'd83028;
      ref_mstatus  = '0;
      ref_mie      = '0;
      ref_mcause   = '0;
      ref_mscratch = '0;
      ref_mtvec    = '0;
      i_rst        = 1'b1;
      i_cmd_valid  = 1'b0;
      i_cmd_op     = OP_RW;
      i_cmd_addr   = '0;
      i_cmd_data   = '0;
      i_rsp_ready  = 1'b1;
      i_mtip       = 1'b0;
      repeat (2) @(posedge i_clk);
      #1;
      i_rst = 1'b0;

      // Old values of mscratch and mtvec are unknown before the first write
      send_cmd(OP_RW, CSR_MSCRATCH, 32'hDEAD_BEEF, 32'h0, 0);
      send_cmd(OP_RW, CSR_MTVEC, 32'h1234_5678, 32'h0, 0);
      send_cmd(OP_RW, CSR_MSCRATCH, 32'hA5A5_0F0F, ALL, 0);
      send_cmd(OP_RS, CSR_MSCRATCH, 32'h0, ALL, 0);
      send_cmd(OP_RW, CSR_MTVEC, 32'h0BAD_F00D, ALL, 3);
      send_cmd(OP_RC, CSR_MTVEC, 32'h0, ALL, 0);

      // Bit-limited CSRs
      for (int k = 0; k < 3; k++) begin
         send_cmd(OP_RS, csr_tab[k], ALL, ALL, 0);
         send_cmd(OP_RS, csr_tab[k], 32'h0, ALL, 0);
         send_cmd(OP_RC, csr_tab[k], ALL, ALL, 2);
         send_cmd(OP_RS, csr_tab[k], 32'h0, ALL, 0);
      end

      for (int k = 3; k < 7; k++) begin
         send_cmd(cmd_op_e'(k), CSR_MSTATUS, ALL, ALL, 0);
         send_cmd(OP_RS, CSR_MCAUSE, 32'h0, ALL, 0);
      end

      // Unknown address leaves everything alone
      send_cmd(OP_RW, 12'h7C0, ALL, ALL, 4);
      for (int k = 0; k < 5; k++) send_cmd(OP_RS, csr_tab[k], 32'h0, ALL, 0);

      // Timer interrupt with both enables, then with either one clear
      send_cmd(OP_RS, CSR_MSTATUS, 32'h8, ALL, 0);
      send_cmd(OP_RS, CSR_MIE, 32'h80, ALL, 0);
      set_mtip(1'b1);
      send_cmd(OP_ECALL, 12'h0, 32'h0, ALL, 0);
      send_cmd(OP_RS, CSR_MCAUSE, 32'h0, ALL, 0);
      set_mtip(1'b0);
      send_cmd(OP_RC, CSR_MIE, 32'h80, ALL, 0);
      set_mtip(1'b1);
      set_mtip(1'b0);
      send_cmd(OP_RS, CSR_MIE, 32'h80, ALL, 0);
      send_cmd(OP_RC, CSR_MSTATUS, 32'h8, ALL, 0);
      set_mtip(1'b1);
      set_mtip(1'b0);
      send_cmd(OP_RS, CSR_MSTATUS, 32'h8, ALL, 0);

      for (int n = 0; n < NUM_RAND; n++) begin
         if (pick(8) == 0) set_mtip(!i_mtip);
         idx = pick(7);
         hi  = lcg_next();
         lo  = lcg_next();
         addr  = (idx < 6) ? csr_tab[idx] : hi[11:0];
         stall = (pick(4) == 0) ? 1 + pick(6) : 0;
         send_cmd(cmd_op_e'(pick(7)), addr, {hi[31:16], lo[31:16]}, ALL, stall);
      end

      repeat (4) tick();
      if (exp_q.size() == 0) begin
         $display("TEST PASS");
         $finish;
      end else begin
         fail_run("Responses were still outstanding at the end of the run");
      end
   end

   // **************************************************
   // Response, timing and interrupt comparison
   // **************************************************
   always @(posedge i_clk) begin
      mon_cyc++;
      if (i_rst) begin
         irq_pred     = 1'b0;
         mtip_last    = 1'b0;
         valid_last   = 1'b0;
         stalled_last = 1'b0;
      end else begin
         check(o_new_irq, irq_pred, "interrupt pulse");
         irq_pred  = !mtip_last & i_mtip & ref_mstatus[3] & ref_mie[7];
         mtip_last = i_mtip;
         if (i_cmd_valid && o_cmd_ready) begin
            acc_cyc  = mon_cyc;
            acc_trap = (i_cmd_op != OP_RW) && (i_cmd_op != OP_RS) && (i_cmd_op != OP_RC);
         end
         if (o_rsp_valid && !valid_last) begin
            check(mon_cyc - acc_cyc, acc_trap ? 2 : 34, "response latency");
         end
         if (stalled_last) begin
            check(o_rsp_valid, 1'b1, "valid held under back-pressure");
            check(o_rsp_data, held_data, "data held under back-pressure");
         end
         if (o_rsp_valid && !i_rsp_ready) check(o_cmd_ready, 1'b0, "cmd ready while stalled");
         if (o_rsp_valid && i_rsp_ready) begin
            if (exp_q.size() == 0) begin
               fail_run("A response arrived with no command outstanding");
            end else begin
               exp_data = exp_q.pop_front();
               care     = care_q.pop_front();
               check(o_rsp_data & care, exp_data & care, "response data");
            end
         end
         stalled_last = o_rsp_valid & !i_rsp_ready;
         held_data    = o_rsp_data;
         valid_last   = o_rsp_valid;
      end
   end

   always @(posedge i_clk) begin
      timeout_cyc++;
      if (timeout_cyc > CYCLE_LIMIT) begin
         fail_run($sformatf("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT));
      end
   end

endmodule

// File: source/csr_top.sv
`timescale 1ns/1ns

module csr_top (
   input  logic                           i_clk,
   input  logic                           i_rst,
   input  logic                           i_cmd_valid,
   input  csr_ctrl_pkg::cmd_op_e          i_cmd_op,
   input  logic [11:0]                    i_cmd_addr,
   input  logic [csr_arch_pkg::XLEN-1:0]  i_cmd_data,
   output logic                           o_cmd_ready,
   output logic                           o_rsp_valid,
   output logic [csr_arch_pkg::XLEN-1:0]  o_rsp_data,
   input  logic                           i_rsp_ready,
   input  logic                           i_mtip,
   output logic                           o_new_irq
);
   import csr_arch_pkg::*;
   import csr_ctrl_pkg::*;

   logic [XLEN-1:0]  operand;
   logic             is_trap;
   logic             trap_go;
   cmd_op_e          trap_op;
   csr_src_e         csr_src;
   logic             mstatus_en;
   logic             mie_en;
   logic             mcause_en;
   logic             mscratch_en;
   logic             mtvec_en;
   logic             busy;
   logic             run;
   logic [CNT_W-1:0] cnt;
   logic             d;
   logic             done;
   logic             rsp_taken;
   logic             csr_in;
   logic             csr_q;
   logic             rf_q;

   // ************************************************
   // Command decode and bit sequencing
   // ************************************************
   csr_decode u_decode (
      .i_clk(i_clk), .i_rst(i_rst), .i_cmd_valid(i_cmd_valid), .i_cmd_op(i_cmd_op),
      .i_cmd_addr(i_cmd_addr), .i_cmd_data(i_cmd_data), .i_busy(busy),
      .o_cmd_ready(o_cmd_ready), .o_operand(operand), .o_is_trap(is_trap),
      .o_trap_go(trap_go), .o_trap_op(trap_op), .o_src(csr_src),
      .o_mstatus_en(mstatus_en), .o_mie_en(mie_en), .o_mcause_en(mcause_en),
      .o_mscratch_en(mscratch_en), .o_mtvec_en(mtvec_en)
   );

   csr_sequencer u_sequencer (
      .i_clk(i_clk), .i_rst(i_rst), .i_start(i_cmd_valid), .i_is_trap(is_trap),
      .i_operand(operand), .i_rsp_taken(rsp_taken), .o_busy(busy), .o_run(run),
      .o_cnt(cnt), .o_d(d), .o_done(done)
   );

   // ************************************************
   // CSR storage and response
   // ************************************************
   csr_bit_unit u_bit_unit (
      .i_clk(i_clk), .i_rst(i_rst), .i_run(run), .i_cnt(cnt), .i_d(d), .i_src(csr_src),
      .i_mstatus_en(mstatus_en), .i_mie_en(mie_en), .i_mcause_en(mcause_en),
      .i_trap_go(trap_go), .i_trap_op(trap_op), .i_mtip(i_mtip), .i_rf_q(rf_q),
      .o_csr_in(csr_in), .o_q(csr_q), .o_new_irq(o_new_irq)
   );

   csr_shift_rf u_shift_rf (
      .i_clk(i_clk), .i_run(run), .i_mscratch_en(mscratch_en), .i_mtvec_en(mtvec_en),
      .i_csr_in(csr_in), .o_q(rf_q)
   );

   csr_result u_result (
      .i_clk(i_clk), .i_rst(i_rst), .i_run(run), .i_q(csr_q), .i_done(done),
      .i_rsp_ready(i_rsp_ready), .o_rsp_valid(o_rsp_valid), .o_rsp_data(o_rsp_data),
      .o_rsp_taken(rsp_taken)
   );

endmodule

// File: source/csr_result.sv
`timescale 1ns/1ns

module csr_result (
   input  logic                           i_clk,
   input  logic                           i_rst,
   input  logic                           i_run,
   input  logic                           i_q,
   input  logic                           i_done,
   input  logic                           i_rsp_ready,
   output logic                           o_rsp_valid,
   output logic [csr_arch_pkg::XLEN-1:0]  o_rsp_data,
   output logic                           o_rsp_taken
);
   import csr_arch_pkg::*;

   assign o_rsp_taken = o_rsp_valid & i_rsp_ready;

   // Word is zero again before the next command starts
   always_ff @(posedge i_clk) begin
      if (i_rst || o_rsp_taken) begin
         o_rsp_data <= '0;
      end else if (i_run) begin
         o_rsp_data <= {i_q, o_rsp_data[XLEN-1:1]};
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_rsp_valid <= 1'b0;
      end else if (i_done) begin
         o_rsp_valid <= 1'b1;
      end else if (o_rsp_taken) begin
         o_rsp_valid <= 1'b0;
      end
   end

endmodule

// File: source/csr_shift_rf.sv
`timescale 1ns/1ns

module csr_shift_rf (
   input  logic i_clk,
   input  logic i_run,
   input  logic i_mscratch_en,
   input  logic i_mtvec_en,
   input  logic i_csr_in,
   output logic o_q
);
   import csr_arch_pkg::*;

   // Entry 0 is mscratch, entry 1 is mtvec
   logic [XLEN-1:0] regs [2];
   logic [1:0]      sel;
   logic [1:0]      q_bits;

   assign sel = {i_mtvec_en, i_mscratch_en};

   always_comb begin
      for (int i = 0; i < 2; i++) begin
         q_bits[i] = i_run & sel[i] & regs[i][0];
      end
   end

   assign o_q = |q_bits;

   // Rotate right, new bit enters at the top
   always_ff @(posedge i_clk) begin
      for (int i = 0; i < 2; i++) begin
         if (i_run & sel[i]) begin
            regs[i] <= {i_csr_in, regs[i][XLEN-1:1]};
         end
      end
   end

endmodule

// File: source/csr_bit_unit.sv
`timescale 1ns/1ns

module csr_bit_unit (
   input  logic                             i_clk,
   input  logic                             i_rst,
   input  logic                             i_run,
   input  logic [csr_ctrl_pkg::CNT_W-1:0]   i_cnt,
   input  logic                             i_d,
   input  csr_ctrl_pkg::csr_src_e           i_src,
   input  logic                             i_mstatus_en,
   input  logic                             i_mie_en,
   input  logic                             i_mcause_en,
   input  logic                             i_trap_go,
   input  csr_ctrl_pkg::cmd_op_e            i_trap_op,
   input  logic                             i_mtip,
   input  logic                             i_rf_q,
   output logic                             o_csr_in,
   output logic                             o_q,
   output logic                             o_new_irq
);
   import csr_arch_pkg::*;
   import csr_ctrl_pkg::*;

   logic       mstatus_mie;
   logic       mie_mtie;
   logic       mcause31;
   logic [3:0] mcause_lo;
   logic       mtip_r;
   logic       slot_mie;
   logic       slot_mtie;
   logic       slot_lo;
   logic       slot_31;
   logic       mcause_bit;
   logic       timer_irq;

   // ************************************************
   // Count slots of the implemented bits
   // ************************************************
   assign slot_mie  = (i_cnt == CNT_W'(MSTATUS_MIE_BIT));
   assign slot_mtie = (i_cnt == CNT_W'(MIE_MTIE_BIT));
   assign slot_lo   = (i_cnt < CNT_W'(4));
   assign slot_31   = (i_cnt == CNT_W'(XLEN - 1));

   assign mcause_bit = slot_lo ? mcause_lo[i_cnt[1:0]] : (slot_31 & mcause31);

   // Old serial value, zero in unimplemented positions
   assign o_q = (i_run & i_mstatus_en & slot_mie & mstatus_mie) |
                (i_run & i_mie_en & slot_mtie & mie_mtie) |
                (i_run & i_mcause_en & mcause_bit) |
                i_rf_q;

   always_comb begin
      case (i_src)
         SRC_EXT: o_csr_in = i_d;
         SRC_SET: o_csr_in = o_q | i_d;
         SRC_CLR: o_csr_in = o_q & ~i_d;
         default: o_csr_in = o_q;
      endcase
   end

   assign timer_irq = i_mtip & mstatus_mie & mie_mtie;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         mstatus_mie <= 1'b0;
         mie_mtie    <= 1'b0;
         mcause31    <= 1'b0;
         mcause_lo   <= '0;
         mtip_r      <= 1'b0;
         o_new_irq   <= 1'b0;
      end else begin
         mtip_r    <= i_mtip;
         o_new_irq <= !mtip_r & timer_irq;

         // Pending timer interrupt wins over the exception cause
         if (i_trap_go) begin
            mcause31 <= timer_irq;
            if (timer_irq) mcause_lo <= CAUSE_TIMER;
            else begin
               case (i_trap_op)
                  OP_ECALL:       mcause_lo <= CAUSE_ECALL;
                  OP_EBREAK:      mcause_lo <= CAUSE_EBREAK;
                  OP_LD_MISALIGN: mcause_lo <= CAUSE_LD_MISALIGN;
                  default:        mcause_lo <= CAUSE_ST_MISALIGN;
               endcase
            end
         end

         if (i_run & i_mstatus_en & slot_mie) mstatus_mie <= o_csr_in;
         if (i_run & i_mie_en & slot_mtie) mie_mtie <= o_csr_in;
         if (i_run & i_mcause_en & slot_lo) mcause_lo[i_cnt[1:0]] <= o_csr_in;
         if (i_run & i_mcause_en & slot_31) mcause31 <= o_csr_in;
      end
   end

endmodule

// File: source/csr_sequencer.sv
`timescale 1ns/1ns

module csr_sequencer (
   input  logic                             i_clk,
   input  logic                             i_rst,
   input  logic                             i_start,
   input  logic                             i_is_trap,
   input  logic [csr_arch_pkg::XLEN-1:0]    i_operand,
   input  logic                             i_rsp_taken,
   output logic                             o_busy,
   output logic                             o_run,
   output logic [csr_ctrl_pkg::CNT_W-1:0]   o_cnt,
   output logic                             o_d,
   output logic                             o_done
);
   import csr_arch_pkg::*;
   import csr_ctrl_pkg::*;

   seq_state_e      state;
   logic [XLEN-1:0] opnd_sr;
   logic            last_bit;

   assign last_bit = (o_cnt == CNT_W'(XLEN - 1));
   assign o_busy   = (state != ST_IDLE);
   assign o_run    = (state == ST_RUN);
   // Traps finish straight out of decode
   assign o_done   = (o_run & last_bit) | ((state == ST_DECODE) & i_is_trap);
   assign o_d      = opnd_sr[0];

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state <= ST_IDLE;
         o_cnt <= '0;
      end else begin
         case (state)
            ST_IDLE:   if (i_start) state <= ST_DECODE;
            ST_DECODE: state <= i_is_trap ? ST_DONE : ST_RUN;
            ST_RUN: begin
               o_cnt <= o_cnt + 1'b1;
               if (last_bit) state <= ST_DONE;
            end
            ST_DONE:   if (i_rsp_taken) state <= ST_IDLE;
            default:   state <= ST_IDLE;
         endcase
      end
   end

   // Operand goes out LSB first
   always_ff @(posedge i_clk) begin
      if (state == ST_DECODE) opnd_sr <= i_operand;
      else if (o_run) opnd_sr <= opnd_sr >> 1;
   end

endmodule

// File: source/csr_decode.sv
`timescale 1ns/1ns

module csr_decode (
   input  logic                           i_clk,
   input  logic                           i_rst,
   input  logic                           i_cmd_valid,
   input  csr_ctrl_pkg::cmd_op_e          i_cmd_op,
   input  logic [11:0]                    i_cmd_addr,
   input  logic [csr_arch_pkg::XLEN-1:0]  i_cmd_data,
   input  logic                           i_busy,
   output logic                           o_cmd_ready,
   output logic [csr_arch_pkg::XLEN-1:0]  o_operand,
   output logic                           o_is_trap,
   output logic                           o_trap_go,
   output csr_ctrl_pkg::cmd_op_e          o_trap_op,
   output csr_ctrl_pkg::csr_src_e         o_src,
   output logic                           o_mstatus_en,
   output logic                           o_mie_en,
   output logic                           o_mcause_en,
   output logic                           o_mscratch_en,
   output logic                           o_mtvec_en
);
   import csr_arch_pkg::*;
   import csr_ctrl_pkg::*;

   logic     accept;
   logic     trap_op;
   csr_src_e src_nxt;

   assign o_cmd_ready = !i_busy;
   assign accept      = i_cmd_valid & o_cmd_ready;

   always_comb begin
      trap_op = 1'b0;
      src_nxt = SRC_CSR;
      case (i_cmd_op)
         OP_RW:   src_nxt = SRC_EXT;
         OP_RS:   src_nxt = SRC_SET;
         OP_RC:   src_nxt = SRC_CLR;
         default: trap_op = 1'b1;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_is_trap     <= 1'b0;
         o_trap_go     <= 1'b0;
         o_src         <= SRC_CSR;
         o_mstatus_en  <= 1'b0;
         o_mie_en      <= 1'b0;
         o_mcause_en   <= 1'b0;
         o_mscratch_en <= 1'b0;
         o_mtvec_en    <= 1'b0;
      end else begin
         o_trap_go <= accept & trap_op;
         if (accept) begin
            o_is_trap     <= trap_op;
            o_src         <= src_nxt;
            // At most one enable, none for traps or unknown addresses
            o_mstatus_en  <= !trap_op & (i_cmd_addr == CSR_MSTATUS);
            o_mie_en      <= !trap_op & (i_cmd_addr == CSR_MIE);
            o_mcause_en   <= !trap_op & (i_cmd_addr == CSR_MCAUSE);
            o_mscratch_en <= !trap_op & (i_cmd_addr == CSR_MSCRATCH);
            o_mtvec_en    <= !trap_op & (i_cmd_addr == CSR_MTVEC);
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (accept) begin
         o_operand <= i_cmd_data;
         o_trap_op <= i_cmd_op;
      end
   end

endmodule

// File: source/csr_ctrl_pkg.sv
package csr_ctrl_pkg;

   // Host command opcodes
   typedef enum logic [2:0] {
      OP_RW          = 3'd0,
      OP_RS          = 3'd1,
      OP_RC          = 3'd2,
      OP_ECALL       = 3'd3,
      OP_EBREAK      = 3'd4,
      OP_LD_MISALIGN = 3'd5,
      OP_ST_MISALIGN = 3'd6
   } cmd_op_e;

   // Source of the new serial CSR bit
   typedef enum logic [1:0] {
      SRC_EXT = 2'd0,
      SRC_SET = 2'd1,
      SRC_CLR = 2'd2,
      SRC_CSR = 2'd3
   } csr_src_e;

   // Sequencer FSM
   typedef enum logic [1:0] {
      ST_IDLE   = 2'd0,
      ST_DECODE = 2'd1,
      ST_RUN    = 2'd2,
      ST_DONE   = 2'd3
   } seq_state_e;

   localparam int CNT_W = 5;

endpackage

// File: source/csr_arch_pkg.sv
package csr_arch_pkg;

   // ************************************************
   // Machine-mode CSR addresses
   // ************************************************
   localparam logic [11:0] CSR_MSTATUS  = 12'h300;
   localparam logic [11:0] CSR_MIE      = 12'h304;
   localparam logic [11:0] CSR_MTVEC    = 12'h305;
   localparam logic [11:0] CSR_MSCRATCH = 12'h340;
   localparam logic [11:0] CSR_MCAUSE   = 12'h342;

   // Implemented field positions
   localparam int MSTATUS_MIE_BIT = 3;
   localparam int MIE_MTIE_BIT    = 7;

   // ************************************************
   // Trap cause codes, low four bits of mcause
   // ************************************************
   localparam logic [3:0] CAUSE_TIMER       = 4'd7;
   localparam logic [3:0] CAUSE_EBREAK      = 4'd3;
   localparam logic [3:0] CAUSE_ECALL       = 4'd11;
   localparam logic [3:0] CAUSE_LD_MISALIGN = 4'd4;
   localparam logic [3:0] CAUSE_ST_MISALIGN = 4'd6;

   // Register width, bit 31 of mcause marks an interrupt
   localparam int XLEN = 32;

endpackage
